//--- hdl/ctrl_pkg.sv
package ctrl_pkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [2:0] step_t;

    // Opcodes
    localparam opcode_t OPC_RTYPE = 6'h00;
    localparam opcode_t OPC_ADDI  = 6'h08;
    localparam opcode_t OPC_ADDIU = 6'h09;
    localparam opcode_t OPC_LW    = 6'h23;
    localparam opcode_t OPC_SW    = 6'h2b;

    // R-type funct field
    localparam funct_t FN_ADD   = 6'h20;
    localparam funct_t FN_SUB   = 6'h22;
    localparam funct_t FN_AND   = 6'h24;
    localparam funct_t FN_SLT   = 6'h2a;
    localparam funct_t FN_JR    = 6'h08;
    localparam funct_t FN_BREAK = 6'h0d;
    localparam funct_t FN_RTE   = 6'h13;
    localparam funct_t FN_SLL   = 6'h00;
    localparam funct_t FN_SRL   = 6'h02;
    localparam funct_t FN_SRA   = 6'h03;
    localparam funct_t FN_SRAV  = 6'h07;
    localparam funct_t FN_SLLV  = 6'h04;

    typedef enum logic [4:0] {
        ST_RESET,
        ST_FETCH,
        ST_DECODE,
        ST_ALU_R,
        ST_ALU_IMM,
        ST_SLT,
        ST_JR,
        ST_RTE,
        ST_BREAK,
        ST_SHIFT_LOAD,
        ST_SLL,
        ST_SRL,
        ST_SRA,
        ST_SRAV,
        ST_SLLV,
        ST_LW,
        ST_SW,
        ST_CLOSE
    } ctrl_state_t;

    // Lengths of the fixed multi-step phases
    localparam step_t FETCH_STEPS  = 3'd4;
    localparam step_t DECODE_STEPS = 3'd3;
    localparam step_t MEM_STEPS    = 3'd4;

    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_PASS = 3'd0;
    localparam alu_op_t ALU_ADD  = 3'd1;
    localparam alu_op_t ALU_SUB  = 3'd2;
    localparam alu_op_t ALU_AND  = 3'd3;
    localparam alu_op_t ALU_SLT  = 3'd7;

    typedef logic [2:0] pc_src_t;
    localparam pc_src_t PC_SRC_ALU = 3'd1;
    localparam pc_src_t PC_SRC_EPC = 3'd3;

    // Register file write data
    typedef logic [2:0] data_src_t;
    localparam data_src_t DATA_SRC_ALUOUT = 3'd1;
    localparam data_src_t DATA_SRC_SHIFT  = 3'd4;
    localparam data_src_t DATA_SRC_SLT    = 3'd6;

    typedef logic [1:0] reg_dst_t;
    localparam reg_dst_t REG_DST_RT = 2'd0;
    localparam reg_dst_t REG_DST_RD = 2'd1;

    typedef logic [1:0] alu_b_t;
    localparam alu_b_t ALU_B_REG    = 2'd0;
    localparam alu_b_t ALU_B_FOUR   = 2'd1;
    localparam alu_b_t ALU_B_IMM    = 2'd2;
    localparam alu_b_t ALU_B_BRANCH = 2'd3;

    // Memory address source
    typedef logic [2:0] iord_t;
    localparam iord_t IORD_PC     = 3'd0;
    localparam iord_t IORD_ALUOUT = 3'd1;

    typedef logic [2:0] shift_op_t;
    localparam shift_op_t SH_NOP       = 3'd0;
    localparam shift_op_t SH_LOAD      = 3'd1;
    localparam shift_op_t SH_LEFT      = 3'd2;
    localparam shift_op_t SH_RIGHT_LOG = 3'd3;
    localparam shift_op_t SH_RIGHT_ARI = 3'd4;

    // Shifter operand and amount select
    typedef logic [1:0] shift_src_t;
    localparam shift_src_t SHSRC_REG = 2'd0;
    localparam shift_src_t SHSRC_IMM = 2'd1;

    typedef struct packed {
        logic       pc_w;
        logic       mem_w;
        logic       ir_w;
        logic       reg_w;
        logic       reg_ab_w;
        logic       aluout_w;
        logic       mdr_w;
        logic       alu_src_a;
        alu_b_t     alu_src_b;
        alu_op_t    alu_op;
        reg_dst_t   reg_dst;
        data_src_t  data_src;
        pc_src_t    pc_src;
        iord_t      i_or_d;
        shift_op_t  shift_ctrl;
        shift_src_t shift_in_sel;
        shift_src_t shift_n_sel;
    } ctrl_word_t;

endpackage

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  ctrl_pkg::opcode_t     i_opcode,
    input  ctrl_pkg::funct_t      i_funct,
    output ctrl_pkg::ctrl_state_t o_exec_state
);

    ctrl_pkg::ctrl_state_t rtype_state;

    // R-type class from funct
    always_comb begin
        case (i_funct)
            ctrl_pkg::FN_ADD,
            ctrl_pkg::FN_SUB,
            ctrl_pkg::FN_AND: begin
                rtype_state = ctrl_pkg::ST_ALU_R;
            end
            ctrl_pkg::FN_SLT: begin
                rtype_state = ctrl_pkg::ST_SLT;
            end
            ctrl_pkg::FN_JR: begin
                rtype_state = ctrl_pkg::ST_JR;
            end
            ctrl_pkg::FN_RTE: begin
                rtype_state = ctrl_pkg::ST_RTE;
            end
            ctrl_pkg::FN_BREAK: begin
                rtype_state = ctrl_pkg::ST_BREAK;
            end
            // Immediate shifts share the load step
            ctrl_pkg::FN_SLL,
            ctrl_pkg::FN_SRL,
            ctrl_pkg::FN_SRA: begin
                rtype_state = ctrl_pkg::ST_SHIFT_LOAD;
            end
            ctrl_pkg::FN_SRAV: begin
                rtype_state = ctrl_pkg::ST_SRAV;
            end
            ctrl_pkg::FN_SLLV: begin
                rtype_state = ctrl_pkg::ST_SLLV;
            end
            default: begin
                rtype_state = ctrl_pkg::ST_CLOSE;
            end
        endcase
    end

    always_comb begin
        case (i_opcode)
            ctrl_pkg::OPC_RTYPE: o_exec_state = rtype_state;
            ctrl_pkg::OPC_ADDI,
            ctrl_pkg::OPC_ADDIU: o_exec_state = ctrl_pkg::ST_ALU_IMM;
            ctrl_pkg::OPC_LW:    o_exec_state = ctrl_pkg::ST_LW;
            ctrl_pkg::OPC_SW:    o_exec_state = ctrl_pkg::ST_SW;
            // Unknown opcode runs as a no-op
            default:             o_exec_state = ctrl_pkg::ST_CLOSE;
        endcase
    end

endmodule

//--- hdl/ctrl_sequencer.sv
`timescale 1ns/1ps

module ctrl_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  ctrl_pkg::opcode_t     i_opcode,
    input  ctrl_pkg::funct_t      i_funct,
    input  ctrl_pkg::ctrl_state_t i_exec_state,
    output ctrl_pkg::ctrl_state_t o_state,
    output ctrl_pkg::step_t       o_step
);

    ctrl_pkg::ctrl_state_t state_q;
    ctrl_pkg::ctrl_state_t next_state;
    ctrl_pkg::step_t       step_q;
    logic                  last_step;
    logic                  halt;

    // Steps spent in each state
    function automatic ctrl_pkg::step_t state_steps(input ctrl_pkg::ctrl_state_t st);
        case (st)
            ctrl_pkg::ST_FETCH:   return ctrl_pkg::FETCH_STEPS;
            ctrl_pkg::ST_DECODE:  return ctrl_pkg::DECODE_STEPS;
            ctrl_pkg::ST_ALU_R,
            ctrl_pkg::ST_ALU_IMM: return 3'd3;
            ctrl_pkg::ST_SLT,
            ctrl_pkg::ST_BREAK,
            ctrl_pkg::ST_SLL,
            ctrl_pkg::ST_SRL,
            ctrl_pkg::ST_SRA,
            ctrl_pkg::ST_SRAV,
            ctrl_pkg::ST_SLLV:    return 3'd2;
            ctrl_pkg::ST_LW,
            ctrl_pkg::ST_SW:      return ctrl_pkg::MEM_STEPS;
            default:              return 3'd1;
        endcase
    endfunction

    assign last_step = (step_q == state_steps(state_q) - 3'd1);

    // Break parks on its second step until reset
    assign halt = (state_q == ctrl_pkg::ST_BREAK) && last_step;

    always_comb begin
        case (state_q)
            ctrl_pkg::ST_RESET:  next_state = ctrl_pkg::ST_FETCH;
            ctrl_pkg::ST_FETCH:  next_state = ctrl_pkg::ST_DECODE;
            ctrl_pkg::ST_DECODE: next_state = i_exec_state;
            ctrl_pkg::ST_BREAK:  next_state = ctrl_pkg::ST_BREAK;
            ctrl_pkg::ST_CLOSE:  next_state = ctrl_pkg::ST_FETCH;
            ctrl_pkg::ST_SHIFT_LOAD: begin
                case (i_funct)
                    ctrl_pkg::FN_SLL: next_state = ctrl_pkg::ST_SLL;
                    ctrl_pkg::FN_SRL: next_state = ctrl_pkg::ST_SRL;
                    ctrl_pkg::FN_SRA: next_state = ctrl_pkg::ST_SRA;
                    default:          next_state = ctrl_pkg::ST_CLOSE;
                endcase
            end
            // Every execute sequence ends by closing the writes
            default:             next_state = ctrl_pkg::ST_CLOSE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ctrl_pkg::ST_RESET;
            step_q  <= '0;
        end else if (!halt) begin
            if (last_step) begin
                state_q <= next_state;
                step_q  <= '0;
            end else begin
                step_q <= step_q + 3'd1;
            end
        end
    end

    assign o_state = state_q;
    assign o_step  = step_q;

    a_step_in_range: assert property (
        @(posedge clk) disable iff (reset)
        step_q < state_steps(state_q)
    ) else $error("step counter past the end of the current state");

    a_close_to_fetch: assert property (
        @(posedge clk) disable iff (reset)
        state_q == ctrl_pkg::ST_CLOSE |=> state_q == ctrl_pkg::ST_FETCH
    ) else $error("close state not followed by fetch");

    // lw must dispatch into its own sequence
    a_lw_dispatch: assert property (
        @(posedge clk) disable iff (reset)
        (state_q == ctrl_pkg::ST_DECODE && last_step && i_opcode == ctrl_pkg::OPC_LW)
            |=> state_q == ctrl_pkg::ST_LW
    ) else $error("lw decoded into the wrong execute state");

endmodule

//--- hdl/ctrl_word_gen.sv
`timescale 1ns/1ps

module ctrl_word_gen (
    input  ctrl_pkg::ctrl_state_t i_state,
    input  ctrl_pkg::step_t       i_step,
    output ctrl_pkg::ctrl_word_t  o_ctrl,
    output logic                  o_rst_out
);

    assign o_rst_out = (i_state == ctrl_pkg::ST_RESET);

    always_comb begin
        // Idle word, no writes
        o_ctrl.pc_w         = 1'b0;
        o_ctrl.mem_w        = 1'b0;
        o_ctrl.ir_w         = 1'b0;
        o_ctrl.reg_w        = 1'b0;
        o_ctrl.reg_ab_w     = 1'b0;
        o_ctrl.aluout_w     = 1'b0;
        o_ctrl.mdr_w        = 1'b0;
        o_ctrl.alu_src_a    = 1'b0;
        o_ctrl.alu_src_b    = ctrl_pkg::ALU_B_REG;
        o_ctrl.alu_op       = ctrl_pkg::ALU_PASS;
        o_ctrl.reg_dst      = ctrl_pkg::REG_DST_RT;
        o_ctrl.data_src     = ctrl_pkg::DATA_SRC_ALUOUT;
        o_ctrl.pc_src       = ctrl_pkg::PC_SRC_ALU;
        o_ctrl.i_or_d       = ctrl_pkg::IORD_PC;
        o_ctrl.shift_ctrl   = ctrl_pkg::SH_NOP;
        o_ctrl.shift_in_sel = ctrl_pkg::SHSRC_REG;
        o_ctrl.shift_n_sel  = ctrl_pkg::SHSRC_REG;

        case (i_state)
            ctrl_pkg::ST_FETCH: begin
                // PC + 4 computed while memory reads the instruction
                o_ctrl.alu_src_b = ctrl_pkg::ALU_B_FOUR;
                o_ctrl.alu_op    = ctrl_pkg::ALU_ADD;
                o_ctrl.ir_w      = (i_step == 3'd3);
                o_ctrl.pc_w      = (i_step == 3'd3);
            end
            ctrl_pkg::ST_DECODE: begin
                // Branch target into ALUOut, operands into A and B
                o_ctrl.alu_src_b = ctrl_pkg::ALU_B_BRANCH;
                o_ctrl.alu_op    = ctrl_pkg::ALU_ADD;
                o_ctrl.reg_ab_w  = (i_step == 3'd0);
                o_ctrl.aluout_w  = (i_step == 3'd0);
            end
            ctrl_pkg::ST_ALU_R,
            ctrl_pkg::ST_ALU_IMM: begin
                o_ctrl.alu_src_a = 1'b1;
                o_ctrl.alu_op    = ctrl_pkg::ALU_ADD;
                o_ctrl.aluout_w  = (i_step == 3'd0);
                o_ctrl.reg_w     = (i_step == 3'd2);
                if (i_state == ctrl_pkg::ST_ALU_R) begin
                    o_ctrl.reg_dst = ctrl_pkg::REG_DST_RD;
                end else begin
                    o_ctrl.alu_src_b = ctrl_pkg::ALU_B_IMM;
                end
            end
            ctrl_pkg::ST_SLT: begin
                o_ctrl.alu_src_a = 1'b1;
                o_ctrl.alu_op    = ctrl_pkg::ALU_SLT;
                o_ctrl.data_src  = ctrl_pkg::DATA_SRC_SLT;
                o_ctrl.reg_dst   = ctrl_pkg::REG_DST_RD;
                o_ctrl.reg_w     = (i_step == 3'd0);
            end
            ctrl_pkg::ST_JR: begin
                // Register value passes straight through to PC
                o_ctrl.alu_src_a = 1'b1;
                o_ctrl.pc_w      = 1'b1;
            end
            ctrl_pkg::ST_RTE: begin
                o_ctrl.pc_src = ctrl_pkg::PC_SRC_EPC;
                o_ctrl.pc_w   = 1'b1;
            end
            ctrl_pkg::ST_BREAK: begin
                // Step PC back to the break instruction
                o_ctrl.alu_src_b = ctrl_pkg::ALU_B_FOUR;
                o_ctrl.alu_op    = ctrl_pkg::ALU_SUB;
                o_ctrl.pc_w      = (i_step == 3'd0);
            end
            ctrl_pkg::ST_SHIFT_LOAD,
            ctrl_pkg::ST_SLL,
            ctrl_pkg::ST_SRL,
            ctrl_pkg::ST_SRA: begin
                // rt and shamt feed the shifter
                o_ctrl.shift_in_sel = ctrl_pkg::SHSRC_IMM;
                o_ctrl.shift_n_sel  = ctrl_pkg::SHSRC_IMM;
                o_ctrl.data_src     = ctrl_pkg::DATA_SRC_SHIFT;
                o_ctrl.reg_dst      = ctrl_pkg::REG_DST_RD;
                if (i_state == ctrl_pkg::ST_SHIFT_LOAD) begin
                    o_ctrl.shift_ctrl = ctrl_pkg::SH_LOAD;
                end else if (i_step == 3'd0) begin
                    if (i_state == ctrl_pkg::ST_SLL) begin
                        o_ctrl.shift_ctrl = ctrl_pkg::SH_LEFT;
                    end else if (i_state == ctrl_pkg::ST_SRL) begin
                        o_ctrl.shift_ctrl = ctrl_pkg::SH_RIGHT_LOG;
                    end else begin
                        o_ctrl.shift_ctrl = ctrl_pkg::SH_RIGHT_ARI;
                    end
                end else begin
                    o_ctrl.reg_w = 1'b1;
                end
            end
            ctrl_pkg::ST_SRAV,
            ctrl_pkg::ST_SLLV: begin
                o_ctrl.data_src = ctrl_pkg::DATA_SRC_SHIFT;
                o_ctrl.reg_dst  = ctrl_pkg::REG_DST_RD;
                if (i_step == 3'd0) begin
                    o_ctrl.shift_ctrl = ctrl_pkg::SH_LOAD;
                end else begin
                    o_ctrl.reg_w      = 1'b1;
                    o_ctrl.shift_ctrl = (i_state == ctrl_pkg::ST_SRAV) ?
                                        ctrl_pkg::SH_RIGHT_ARI : ctrl_pkg::SH_LEFT;
                end
            end
            ctrl_pkg::ST_LW,
            ctrl_pkg::ST_SW: begin
                // Base plus offset addresses memory
                o_ctrl.alu_src_a = 1'b1;
                o_ctrl.alu_src_b = ctrl_pkg::ALU_B_IMM;
                o_ctrl.alu_op    = ctrl_pkg::ALU_ADD;
                o_ctrl.i_or_d    = ctrl_pkg::IORD_ALUOUT;
                o_ctrl.mdr_w     = 1'b1;
                o_ctrl.mem_w     = (i_state == ctrl_pkg::ST_SW) && (i_step == 3'd3);
                o_ctrl.reg_w     = (i_state == ctrl_pkg::ST_LW) && (i_step == 3'd3);
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        assert (!(o_ctrl.mem_w && o_ctrl.reg_w))
            else $error("mem_w and reg_w high in the same cycle");
        assert (!o_ctrl.ir_w || o_ctrl.pc_w)
            else $error("ir_w without pc_w");
    end

endmodule

//--- hdl/ctrl_unit.sv
`timescale 1ns/1ps

module ctrl_unit (
    input  logic       clk,
    input  logic       reset,
    input  logic [5:0] i_opcode,
    input  logic [5:0] i_funct,
    output logic       o_pc_w,
    output logic       o_mem_w,
    output logic       o_ir_w,
    output logic       o_reg_w,
    output logic       o_reg_ab_w,
    output logic       o_aluout_w,
    output logic       o_mdr_w,
    output logic       o_alu_src_a,
    output logic [1:0] o_alu_src_b,
    output logic [2:0] o_alu_op,
    output logic [1:0] o_reg_dst,
    output logic [2:0] o_data_src,
    output logic [2:0] o_pc_src,
    output logic [2:0] o_i_or_d,
    output logic [2:0] o_shift_ctrl,
    output logic [1:0] o_shift_in_sel,
    output logic [1:0] o_shift_n_sel,
    output logic       o_rst_out
);

    ctrl_pkg::ctrl_state_t exec_state;
    ctrl_pkg::ctrl_state_t state;
    ctrl_pkg::step_t       step;
    ctrl_pkg::ctrl_word_t  ctrl;

    instr_decoder instr_decoder_inst (
        .i_opcode     (i_opcode),
        .i_funct      (i_funct),
        .o_exec_state (exec_state)
    );

    ctrl_sequencer ctrl_sequencer_inst (
        .clk          (clk),
        .reset        (reset),
        .i_opcode     (i_opcode),
        .i_funct      (i_funct),
        .i_exec_state (exec_state),
        .o_state      (state),
        .o_step       (step)
    );

    ctrl_word_gen ctrl_word_gen_inst (
        .i_state   (state),
        .i_step    (step),
        .o_ctrl    (ctrl),
        .o_rst_out (o_rst_out)
    );

    // Control word fields onto individual pins
    assign o_pc_w         = ctrl.pc_w;
    assign o_mem_w        = ctrl.mem_w;
    assign o_ir_w         = ctrl.ir_w;
    assign o_reg_w        = ctrl.reg_w;
    assign o_reg_ab_w     = ctrl.reg_ab_w;
    assign o_aluout_w     = ctrl.aluout_w;
    assign o_mdr_w        = ctrl.mdr_w;
    assign o_alu_src_a    = ctrl.alu_src_a;
    assign o_alu_src_b    = ctrl.alu_src_b;
    assign o_alu_op       = ctrl.alu_op;
    assign o_reg_dst      = ctrl.reg_dst;
    assign o_data_src     = ctrl.data_src;
    assign o_pc_src       = ctrl.pc_src;
    assign o_i_or_d       = ctrl.i_or_d;
    assign o_shift_ctrl   = ctrl.shift_ctrl;
    assign o_shift_in_sel = ctrl.shift_in_sel;
    assign o_shift_n_sel  = ctrl.shift_n_sel;

endmodule

//--- testbench/ctrl_tb_table.svh
`ifndef CTRL_TB_TABLE_SVH
`define CTRL_TB_TABLE_SVH

// Columns: name, opcode, funct, execute steps, halts, reg_w / mem_w / pc_w pulses per gap,
// then alu_op, data_src, reg_dst at the reg_w pulse and pc_src at any pc_w pulse
task automatic load_table();
    add_row("add",     6'h00, 6'h20, 3, 1'b0, 1, 0, 0, 3'd1, 3'd1, 2'd1, 3'd1);
    add_row("sub",     6'h00, 6'h22, 3, 1'b0, 1, 0, 0, 3'd1, 3'd1, 2'd1, 3'd1);
    add_row("and",     6'h00, 6'h24, 3, 1'b0, 1, 0, 0, 3'd1, 3'd1, 2'd1, 3'd1);
    add_row("slt",     6'h00, 6'h2a, 2, 1'b0, 1, 0, 0, 3'd7, 3'd6, 2'd1, 3'd1);
    add_row("addi",    6'h08, 6'h00, 3, 1'b0, 1, 0, 0, 3'd1, 3'd1, 2'd0, 3'd1);
    add_row("addiu",   6'h09, 6'h00, 3, 1'b0, 1, 0, 0, 3'd1, 3'd1, 2'd0, 3'd1);
    // Immediate shifts take the load step plus two
    add_row("sll",     6'h00, 6'h00, 3, 1'b0, 1, 0, 0, 3'd0, 3'd4, 2'd1, 3'd1);
    add_row("srl",     6'h00, 6'h02, 3, 1'b0, 1, 0, 0, 3'd0, 3'd4, 2'd1, 3'd1);
    add_row("sra",     6'h00, 6'h03, 3, 1'b0, 1, 0, 0, 3'd0, 3'd4, 2'd1, 3'd1);
    add_row("sllv",    6'h00, 6'h04, 2, 1'b0, 1, 0, 0, 3'd0, 3'd4, 2'd1, 3'd1);
    add_row("srav",    6'h00, 6'h07, 2, 1'b0, 1, 0, 0, 3'd0, 3'd4, 2'd1, 3'd1);
    add_row("jr",      6'h00, 6'h08, 1, 1'b0, 0, 0, 1, 3'd0, 3'd0, 2'd0, 3'd1);
    add_row("rte",     6'h00, 6'h13, 1, 1'b0, 0, 0, 1, 3'd0, 3'd0, 2'd0, 3'd3);
    add_row("lw",      6'h23, 6'h00, 4, 1'b0, 1, 0, 0, 3'd1, 3'd1, 2'd0, 3'd1);
    add_row("sw",      6'h2b, 6'h00, 4, 1'b0, 0, 1, 0, 3'd0, 3'd0, 2'd0, 3'd1);
    // Unknown opcode goes straight to close
    add_row("unknown", 6'h3f, 6'h00, 0, 1'b0, 0, 0, 0, 3'd0, 3'd0, 2'd0, 3'd1);
    add_row("break",   6'h00, 6'h0d, 0, 1'b1, 0, 0, 1, 3'd0, 3'd0, 2'd0, 3'd1);
endtask

`endif

//--- testbench/ctrl_unit_tb.sv
`timescale 1ns/1ps

module ctrl_unit_tb;

    typedef struct packed {
        logic [5:0] opcode;
        logic [5:0] funct;
        int         exec_len;
        logic       halts;
        int         n_reg_w;
        int         n_mem_w;
        int         n_pc_w;
        logic [2:0] alu_op;
        logic [2:0] data_src;
        logic [1:0] reg_dst;
        logic [2:0] pc_src;
    } row_t;

    logic       clk;
    logic       reset;
    logic [5:0] i_opcode;
    logic [5:0] i_funct;
    logic       o_pc_w;
    logic       o_mem_w;
    logic       o_ir_w;
    logic       o_reg_w;
    logic       o_reg_ab_w;
    logic       o_aluout_w;
    logic       o_mdr_w;
    logic       o_alu_src_a;
    logic [1:0] o_alu_src_b;
    logic [2:0] o_alu_op;
    logic [1:0] o_reg_dst;
    logic [2:0] o_data_src;
    logic [2:0] o_pc_src;
    logic [2:0] o_i_or_d;
    logic [2:0] o_shift_ctrl;
    logic [1:0] o_shift_in_sel;
    logic [1:0] o_shift_n_sel;
    logic       o_rst_out;

    row_t  rows[$];
    string row_names[$];
    int    errors;
    int    tests_passed;
    int    tests_failed;
    logic  table_ready;

    ctrl_unit ctrl_unit_inst (
        .clk            (clk),
        .reset          (reset),
        .i_opcode       (i_opcode),
        .i_funct        (i_funct),
        .o_pc_w         (o_pc_w),
        .o_mem_w        (o_mem_w),
        .o_ir_w         (o_ir_w),
        .o_reg_w        (o_reg_w),
        .o_reg_ab_w     (o_reg_ab_w),
        .o_aluout_w     (o_aluout_w),
        .o_mdr_w        (o_mdr_w),
        .o_alu_src_a    (o_alu_src_a),
        .o_alu_src_b    (o_alu_src_b),
        .o_alu_op       (o_alu_op),
        .o_reg_dst      (o_reg_dst),
        .o_data_src     (o_data_src),
        .o_pc_src       (o_pc_src),
        .o_i_or_d       (o_i_or_d),
        .o_shift_ctrl   (o_shift_ctrl),
        .o_shift_in_sel (o_shift_in_sel),
        .o_shift_n_sel  (o_shift_n_sel),
        .o_rst_out      (o_rst_out)
    );

    task automatic add_row(input string name, input logic [5:0] opcode,
                           input logic [5:0] funct, input int exec_len, input logic halts,
                           input int n_reg_w, input int n_mem_w, input int n_pc_w,
                           input logic [2:0] alu_op, input logic [2:0] data_src,
                           input logic [1:0] reg_dst, input logic [2:0] pc_src);
        row_t r;
        r.opcode   = opcode;
        r.funct    = funct;
        r.exec_len = exec_len;
        r.halts    = halts;
        r.n_reg_w  = n_reg_w;
        r.n_mem_w  = n_mem_w;
        r.n_pc_w   = n_pc_w;
        r.alu_op   = alu_op;
        r.data_src = data_src;
        r.reg_dst  = reg_dst;
        r.pc_src   = pc_src;
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    `include "ctrl_tb_table.svh"

    task automatic show_mismatch(input string test, input string sig, input int got,
                                 input int expected);
        $display("ERROR %s: %s = 0x%0h, expected 0x%0h", test, sig, got, expected);
        errors++;
    endtask

    task automatic show_failure(input string test, input string what);
        $display("%s: %s", test, what);
        errors++;
    endtask

    task automatic finish_test(input string test, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: ok", test);
        end else begin
            tests_failed++;
            $display("test %s: failed", test);
        end
    endtask

    function automatic logic [6:0] write_enables();
        return {o_pc_w, o_mem_w, o_ir_w, o_reg_w, o_reg_ab_w, o_aluout_w, o_mdr_w};
    endfunction

    // Last fetch step latches IR and PC + 4 from the ALU
    task automatic check_fetch_word(input string test);
        if (write_enables() !== 7'b1010000) begin
            show_mismatch(test, "write enables", int'(write_enables()), 'h50);
        end
        if (o_alu_src_a !== 1'b0) begin
            show_mismatch(test, "o_alu_src_a", int'(o_alu_src_a), 0);
        end
        if (o_alu_src_b !== ctrl_pkg::ALU_B_FOUR) begin
            show_mismatch(test, "o_alu_src_b", int'(o_alu_src_b), int'(ctrl_pkg::ALU_B_FOUR));
        end
        if (o_alu_op !== ctrl_pkg::ALU_ADD) begin
            show_mismatch(test, "o_alu_op", int'(o_alu_op), int'(ctrl_pkg::ALU_ADD));
        end
        if (o_pc_src !== ctrl_pkg::PC_SRC_ALU) begin
            show_mismatch(test, "o_pc_src", int'(o_pc_src), int'(ctrl_pkg::PC_SRC_ALU));
        end
        if (o_i_or_d !== ctrl_pkg::IORD_PC) begin
            show_mismatch(test, "o_i_or_d", int'(o_i_or_d), int'(ctrl_pkg::IORD_PC));
        end
        if (o_shift_ctrl !== ctrl_pkg::SH_NOP) begin
            show_mismatch(test, "o_shift_ctrl", int'(o_shift_ctrl), int'(ctrl_pkg::SH_NOP));
        end
        if (o_shift_in_sel !== ctrl_pkg::SHSRC_REG) begin
            show_mismatch(test, "o_shift_in_sel", int'(o_shift_in_sel),
                          int'(ctrl_pkg::SHSRC_REG));
        end
        if (o_shift_n_sel !== ctrl_pkg::SHSRC_REG) begin
            show_mismatch(test, "o_shift_n_sel", int'(o_shift_n_sel),
                          int'(ctrl_pkg::SHSRC_REG));
        end
    endtask

    // Reset release up to the first instruction fetch
    task automatic check_startup();
        int   errors_before;
        int   rst_cycles;
        int   cycle;
        logic seen_ir;
        errors_before = errors;
        rst_cycles    = 0;
        cycle         = 0;
        seen_ir       = 1'b0;
        @(negedge clk);
        // Last cycle in ST_RESET before the rising edge that sees reset low
        if (o_rst_out) rst_cycles++;
        if (write_enables() != 7'b0) begin
            show_mismatch("startup", "write enables", int'(write_enables()), 0);
        end
        reset = 1'b0;
        while (!seen_ir) begin
            @(negedge clk);
            cycle++;
            if (o_rst_out) rst_cycles++;
            if (o_ir_w) begin
                seen_ir = 1'b1;
                check_fetch_word("startup");
            end else if (write_enables() != 7'b0) begin
                show_mismatch("startup", "write enables", int'(write_enables()), 0);
            end
        end
        if (rst_cycles != 1) show_mismatch("startup", "o_rst_out cycles", rst_cycles, 1);
        if (cycle != 4) show_mismatch("startup", "cycles to first o_ir_w", cycle, 4);
        finish_test("startup", errors_before);
    endtask

    // Entered on the falling edge where the previous o_ir_w was seen
    task automatic run_row(input int idx);
        row_t  r;
        string name;
        int    errors_before;
        int    gap;
        int    n_reg_w;
        int    n_mem_w;
        int    n_pc_w;
        logic  seen_ir;
        r             = rows[idx];
        name          = row_names[idx];
        errors_before = errors;
        gap           = 0;
        n_reg_w       = 0;
        n_mem_w       = 0;
        n_pc_w        = 0;
        seen_ir       = 1'b0;
        i_opcode      = r.opcode;
        i_funct       = r.funct;
        if (r.halts) begin
            repeat (50) begin
                @(negedge clk);
                if (o_ir_w) seen_ir = 1'b1;
                if (o_pc_w) n_pc_w++;
            end
            if (seen_ir) show_failure(name, "break did not halt, o_ir_w came back");
            if (n_pc_w != r.n_pc_w) show_mismatch(name, "o_pc_w pulses", n_pc_w, r.n_pc_w);
        end else begin
            while (!seen_ir) begin
                @(negedge clk);
                gap++;
                if (o_ir_w) begin
                    seen_ir = 1'b1;
                    check_fetch_word(name);
                end else begin
                    if (o_reg_w) begin
                        n_reg_w++;
                        if (r.n_reg_w > 0 && o_alu_op !== r.alu_op) begin
                            show_mismatch(name, "o_alu_op", int'(o_alu_op), int'(r.alu_op));
                        end
                        if (r.n_reg_w > 0 && o_data_src !== r.data_src) begin
                            show_mismatch(name, "o_data_src", int'(o_data_src),
                                          int'(r.data_src));
                        end
                        if (r.n_reg_w > 0 && o_reg_dst !== r.reg_dst) begin
                            show_mismatch(name, "o_reg_dst", int'(o_reg_dst), int'(r.reg_dst));
                        end
                    end
                    if (o_mem_w) begin
                        n_mem_w++;
                        // Store goes to the base plus offset address
                        if (o_i_or_d !== ctrl_pkg::IORD_ALUOUT) begin
                            show_mismatch(name, "o_i_or_d", int'(o_i_or_d),
                                          int'(ctrl_pkg::IORD_ALUOUT));
                        end
                    end
                    if (o_pc_w) begin
                        n_pc_w++;
                        if (o_pc_src !== r.pc_src) begin
                            show_mismatch(name, "o_pc_src", int'(o_pc_src), int'(r.pc_src));
                        end
                    end
                end
            end
            if (gap != 8 + r.exec_len) show_mismatch(name, "o_ir_w gap", gap, 8 + r.exec_len);
            if (n_reg_w != r.n_reg_w) show_mismatch(name, "o_reg_w pulses", n_reg_w, r.n_reg_w);
            if (n_mem_w != r.n_mem_w) show_mismatch(name, "o_mem_w pulses", n_mem_w, r.n_mem_w);
            if (n_pc_w != r.n_pc_w) show_mismatch(name, "o_pc_w pulses", n_pc_w, r.n_pc_w);
        end
        finish_test(name, errors_before);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!reset && o_mem_w && o_reg_w) begin
            show_failure("observer", "o_mem_w and o_reg_w were high in the same cycle");
        end
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = rows.size() * 16 + 60;
        repeat (limit) @(posedge clk);
        $display("timeout: run did not complete within %0d cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int idx;
        reset        = 1'b1;
        i_opcode     = 6'h00;
        i_funct      = 6'h00;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        table_ready  = 1'b0;
        load_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        check_startup();
        for (idx = 0; idx < rows.size(); idx++) begin
            run_row(idx);
        end
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+testbench
hdl/ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/ctrl_sequencer.sv
hdl/ctrl_word_gen.sv
hdl/ctrl_unit.sv
testbench/ctrl_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ctrl_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f \
    --top-module ctrl_unit_tb -Mdir obj_dir -o ctrl_unit_tb
if [ $? -ne 0 ]; then
    echo "run_sim: compile step failed"
    exit 1
fi

./obj_dir/ctrl_unit_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "run_sim: testbench reported failures"
    exit 1
fi
echo "run_sim: testbench passed"
exit 0
